// File: hdl/opcol_cfg.svh
`ifndef OPCOL_CFG_SVH
`define OPCOL_CFG_SVH

// hardware warps and architectural registers per warp
`define OPCOL_WARPS          8
`define OPCOL_REGS_PER_WARP  8

// register file organisation
`define OPCOL_BANKS          4
`define OPCOL_ROWS           16
`define OPCOL_LANES          8
`define OPCOL_LANE_W         32

// collector entries and per-bank request queue depth
`define OPCOL_ENTRIES        4
`define OPCOL_QUEUE_DEPTH    8

`endif

// File: hdl/opcol_pkg.sv
`default_nettype none

`include "opcol_cfg.svh"

package opcol_pkg;

    typedef logic [$clog2(`OPCOL_WARPS)-1:0]         warp_id_t;
    typedef logic [$clog2(`OPCOL_REGS_PER_WARP)-1:0] reg_id_t;
    typedef logic [$clog2(`OPCOL_ROWS)-1:0]          row_id_t;
    typedef logic [$clog2(`OPCOL_BANKS)-1:0]         bank_id_t;
    typedef logic [$clog2(`OPCOL_ENTRIES)-1:0]       entry_id_t;
    typedef logic [`OPCOL_LANES*`OPCOL_LANE_W-1:0]   vec_t;
    typedef logic [`OPCOL_LANES-1:0]                 mask_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  dst;
        logic [15:0] imme;
        logic        imme_valid;
        logic [3:0]  aluop;
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        mask_t       active_mask;
    } ctrl_t;

    typedef struct packed {
        warp_id_t warp;
        reg_id_t  src1;
        logic     src1_valid;
        reg_id_t  src2;
        logic     src2_valid;
        ctrl_t    ctrl;
    } issue_t;

    typedef struct packed {
        warp_id_t warp;
        reg_id_t  reg_num;
        mask_t    mask;
        vec_t     data;
    } wb_t;

    typedef struct packed {
        row_id_t   row;
        entry_id_t entry;
        logic      slot;   // 0 src1, 1 src2
    } read_req_t;

    typedef struct packed {
        logic      valid;
        entry_id_t entry;
        logic      slot;
        vec_t      data;
    } read_rsp_t;

    typedef struct packed {
        ctrl_t ctrl;
        vec_t  src1_data;
        vec_t  src2_data;
    } dispatch_t;

    // static placement of architectural registers, shifted by warp to spread banks
    function automatic bank_id_t bank_of(warp_id_t w, reg_id_t r);
        return bank_id_t'((int'(w) + int'(r)) % `OPCOL_BANKS);
    endfunction

    function automatic row_id_t row_of(warp_id_t w, reg_id_t r);
        return row_id_t'(int'(w) * (`OPCOL_REGS_PER_WARP / `OPCOL_BANKS)
                         + int'(r) / `OPCOL_BANKS);
    endfunction

endpackage

`default_nettype wire

// File: hdl/collector_units.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module collector_units
    import opcol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      issue_valid,
    input  issue_t    issue,
    output entry_id_t alloc_id,
    output logic      full,

    input  read_rsp_t rsp [`OPCOL_BANKS],
    input  logic [`OPCOL_ENTRIES-1:0] grant,

    output ctrl_t     entry_ctrl [`OPCOL_ENTRIES],
    output vec_t      entry_src1 [`OPCOL_ENTRIES],
    output vec_t      entry_src2 [`OPCOL_ENTRIES],
    output logic [`OPCOL_ENTRIES-1:0] ready
);

    localparam int ENTRIES = `OPCOL_ENTRIES;
    localparam int BANKS   = `OPCOL_BANKS;

    logic [ENTRIES-1:0] busy;
    logic [ENTRIES-1:0] has1;   // src1 present
    logic [ENTRIES-1:0] has2;   // src2 present

    assign full  = &busy;
    assign ready = busy & has1 & has2;

    // lowest free entry
    always_comb begin
        alloc_id = '0;
        for (int e = ENTRIES - 1; e >= 0; e--) begin
            if (!busy[e]) begin
                alloc_id = entry_id_t'(e);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            has1 <= '0;
            has2 <= '0;
        end else begin
            busy <= busy & ~grant;
            if (issue_valid) begin
                busy[alloc_id] <= 1'b1;
                has1[alloc_id] <= ~issue.src1_valid;   // unused source counts as present
                has2[alloc_id] <= ~issue.src2_valid;
            end
            for (int b = 0; b < BANKS; b++) begin
                if (rsp[b].valid) begin
                    if (rsp[b].slot) begin
                        has2[rsp[b].entry] <= 1'b1;
                    end else begin
                        has1[rsp[b].entry] <= 1'b1;
                    end
                end
            end
        end
    end

    // operand and control storage
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            entry_ctrl[alloc_id] <= issue.ctrl;
            entry_src1[alloc_id] <= '0;   // stays zero if source unused
            entry_src2[alloc_id] <= '0;
        end
        for (int b = 0; b < BANKS; b++) begin
            if (rsp[b].valid) begin
                if (rsp[b].slot) begin
                    entry_src2[rsp[b].entry] <= rsp[b].data;
                end else begin
                    entry_src1[rsp[b].entry] <= rsp[b].data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_map.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module reg_map
    import opcol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  issue_t    issue,
    input  entry_id_t alloc_id,
    output logic [`OPCOL_BANKS-1:0] push1,
    output logic [`OPCOL_BANKS-1:0] push2,
    output read_req_t req1 [`OPCOL_BANKS],
    output read_req_t req2 [`OPCOL_BANKS]
);

    localparam int BANKS = `OPCOL_BANKS;

    logic [BANKS-1:0] push1_d;
    logic [BANKS-1:0] push2_d;
    read_req_t        req1_d [BANKS];
    read_req_t        req2_d [BANKS];
    bank_id_t         bank1;
    bank_id_t         bank2;

    assign bank1 = bank_of(issue.warp, issue.src1);
    assign bank2 = bank_of(issue.warp, issue.src2);

    always_comb begin
        push1_d = '0;
        push2_d = '0;
        for (int b = 0; b < BANKS; b++) begin
            req1_d[b] = '0;
            req2_d[b] = '0;
        end
        if (issue_valid && issue.src1_valid) begin
            push1_d[bank1] = 1'b1;
            req1_d[bank1]  = '{row: row_of(issue.warp, issue.src1), entry: alloc_id, slot: 1'b0};
        end
        if (issue_valid && issue.src2_valid) begin
            if (issue.src1_valid && bank1 == bank2) begin   // same bank, queued behind src1
                push2_d[bank2] = 1'b1;
                req2_d[bank2]  = '{row: row_of(issue.warp, issue.src2), entry: alloc_id,
                                   slot: 1'b1};
            end else begin
                push1_d[bank2] = 1'b1;
                req1_d[bank2]  = '{row: row_of(issue.warp, issue.src2), entry: alloc_id,
                                   slot: 1'b1};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push1 <= '0;
            push2 <= '0;
        end else begin
            push1 <= push1_d;
            push2 <= push2_d;
        end
    end

    always_ff @(posedge clk) begin
        req1 <= req1_d;
        req2 <= req2_d;
    end

endmodule

`default_nettype wire

// File: hdl/bank_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module bank_queue
    import opcol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      push1,
    input  logic      push2,
    input  read_req_t req1,
    input  read_req_t req2,

    input  logic      pop,
    output read_req_t head,
    output logic      not_empty
);

    localparam int DEPTH = `OPCOL_QUEUE_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    read_req_t       mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [PW:0]     count;
    logic [1:0]      n_push;

    assign n_push    = {1'b0, push1} + {1'b0, push2};
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PW'(n_push);
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PW+1)'(n_push) - (PW+1)'(pop);
        end
    end

    // src1 takes the first free slot, src2 the one behind it
    always_ff @(posedge clk) begin
        if (push1) begin
            mem[wr_ptr] <= req1;
        end
        if (push2) begin
            mem[wr_ptr + PW'(push1)] <= req2;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module reg_bank
    import opcol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      wr_en,
    input  row_id_t   wr_row,
    input  mask_t     wr_mask,
    input  vec_t      wr_data,

    input  read_req_t head,
    input  logic      not_empty,
    output logic      pop,
    output read_rsp_t rsp
);

    localparam int ROWS   = `OPCOL_ROWS;
    localparam int LANES  = `OPCOL_LANES;
    localparam int LANE_W = `OPCOL_LANE_W;

    vec_t      mem [ROWS];
    logic      rsp_valid;
    entry_id_t rsp_entry;
    logic      rsp_slot;
    vec_t      rsp_data;

    assign pop = not_empty & ~wr_en;   // writeback owns the port this cycle
    assign rsp = '{valid: rsp_valid, entry: rsp_entry, slot: rsp_slot, data: rsp_data};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_row][i*LANE_W +: LANE_W] <= wr_data[i*LANE_W +: LANE_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsp_entry <= head.entry;
            rsp_slot  <= head.slot;
            rsp_data  <= mem[head.row];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatch_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module dispatch_arbiter
    import opcol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic [`OPCOL_ENTRIES-1:0] ready,
    input  ctrl_t     entry_ctrl [`OPCOL_ENTRIES],
    input  vec_t      entry_src1 [`OPCOL_ENTRIES],
    input  vec_t      entry_src2 [`OPCOL_ENTRIES],
    output logic [`OPCOL_ENTRIES-1:0] grant,

    output logic      alu_valid,
    output dispatch_t alu,
    output logic      mem_valid,
    output dispatch_t mem
);

    localparam int ENTRIES = `OPCOL_ENTRIES;

    logic [ENTRIES-1:0] is_mem;
    logic [ENTRIES-1:0] alu_req;
    logic [ENTRIES-1:0] mem_req;
    entry_id_t          alu_last;
    entry_id_t          mem_last;
    entry_id_t          alu_pick;
    entry_id_t          mem_pick;

    // first requester after the previous winner, wrapping around
    function automatic entry_id_t rr_pick(input logic [ENTRIES-1:0] req, input entry_id_t last);
        entry_id_t idx;
        entry_id_t pick;
        pick = last;
        for (int k = ENTRIES; k >= 1; k--) begin
            idx = last + entry_id_t'(k);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    always_comb begin
        for (int e = 0; e < ENTRIES; e++) begin
            is_mem[e] = entry_ctrl[e].mem_read | entry_ctrl[e].mem_write;
        end
    end

    assign alu_req  = ready & ~is_mem;
    assign mem_req  = ready & is_mem;
    assign alu_pick = rr_pick(alu_req, alu_last);
    assign mem_pick = rr_pick(mem_req, mem_last);

    always_comb begin
        grant = '0;
        if (|alu_req) grant[alu_pick] = 1'b1;
        if (|mem_req) grant[mem_pick] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
            alu_last  <= '0;
            mem_last  <= '0;
        end else begin
            alu_valid <= |alu_req;
            mem_valid <= |mem_req;
            if (|alu_req) alu_last <= alu_pick;
            if (|mem_req) mem_last <= mem_pick;
        end
    end

    always_ff @(posedge clk) begin
        alu <= '{ctrl: entry_ctrl[alu_pick], src1_data: entry_src1[alu_pick],
                 src2_data: entry_src2[alu_pick]};
        mem <= '{ctrl: entry_ctrl[mem_pick], src1_data: entry_src1[mem_pick],
                 src2_data: entry_src2[mem_pick]};
    end

endmodule

`default_nettype wire

// File: hdl/opcol_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module opcol_top
    import opcol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  issue_t    issue,
    output logic      full,
    input  logic      wb_valid,
    input  wb_t       wb,
    output logic      alu_valid,
    output dispatch_t alu,
    output logic      mem_valid,
    output dispatch_t mem
);

    localparam int BANKS   = `OPCOL_BANKS;
    localparam int ENTRIES = `OPCOL_ENTRIES;

    entry_id_t          alloc_id;
    logic [BANKS-1:0]   push1;
    logic [BANKS-1:0]   push2;
    read_req_t          req1 [BANKS];
    read_req_t          req2 [BANKS];
    read_req_t          head [BANKS];
    logic [BANKS-1:0]   not_empty;
    logic [BANKS-1:0]   pop;
    logic [BANKS-1:0]   wr_en;
    read_rsp_t          rsp [BANKS];
    logic [ENTRIES-1:0] grant;
    logic [ENTRIES-1:0] ready;
    ctrl_t              entry_ctrl [ENTRIES];
    vec_t               entry_src1 [ENTRIES];
    vec_t               entry_src2 [ENTRIES];
    bank_id_t           wb_bank;
    row_id_t            wb_row;

    assign wb_bank = bank_of(wb.warp, wb.reg_num);
    assign wb_row  = row_of(wb.warp, wb.reg_num);

    collector_units i_collector_units (
        .clk, .rst, .issue_valid, .issue, .alloc_id, .full, .rsp, .grant,
        .entry_ctrl, .entry_src1, .entry_src2, .ready
    );

    reg_map i_reg_map (
        .clk, .rst, .issue_valid, .issue, .alloc_id, .push1, .push2, .req1, .req2
    );

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        assign wr_en[b] = wb_valid && (wb_bank == bank_id_t'(b));

        bank_queue i_bank_queue (
            .clk, .rst, .push1(push1[b]), .push2(push2[b]), .req1(req1[b]), .req2(req2[b]),
            .pop(pop[b]), .head(head[b]), .not_empty(not_empty[b])
        );

        reg_bank i_reg_bank (
            .clk, .rst, .wr_en(wr_en[b]), .wr_row(wb_row), .wr_mask(wb.mask),
            .wr_data(wb.data), .head(head[b]), .not_empty(not_empty[b]), .pop(pop[b]),
            .rsp(rsp[b])
        );
    end

    dispatch_arbiter i_dispatch_arbiter (
        .clk, .rst, .ready, .entry_ctrl, .entry_src1, .entry_src2, .grant,
        .alu_valid, .alu, .mem_valid, .mem
    );

endmodule

`default_nettype wire

// File: bench/opcol_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "opcol_cfg.svh"

module opcol_tb
    import opcol_pkg::*;
();

    localparam int NREGS         = `OPCOL_WARPS * `OPCOL_REGS_PER_WARP;
    localparam int CONFLICT_BANK = 2;
    localparam int LEN_INIT      = 192;   // rough cycle budget per test
    localparam int LEN_MASK      = 96;
    localparam int LEN_CLASS     = 128;
    localparam int LEN_CONFLICT  = 192;
    localparam int LEN_FULL      = 96;
    localparam int MAX_CYCLES    =
        (LEN_INIT + LEN_MASK + LEN_CLASS + LEN_CONFLICT + LEN_FULL) * 4 + 200;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    issue_t    issue;
    logic      full;
    logic      wb_valid;
    wb_t       wb;
    logic      alu_valid;
    dispatch_t alu;
    logic      mem_valid;
    dispatch_t mem;

    vec_t        regs [NREGS];       // architectural register model
    int          inflight [NREGS];   // pending reads per register
    dispatch_t   exp_disp [int unsigned];
    issue_t      issued [int unsigned];
    int unsigned next_tag = 32'h100;
    int          errors = 0;
    int          cycles = 0;
    int          tests_run = 0;
    int          tests_passed = 0;

    opcol_top i_opcol_top (
        .clk, .rst, .issue_valid, .issue, .full, .wb_valid, .wb,
        .alu_valid, .alu, .mem_valid, .mem
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: timeout at cycle %0d with %0d dispatches never seen",
                     cycles, exp_disp.num());
            $display("Test failed");
            $finish;
        end
    end

    function automatic int reg_index(input warp_id_t w, input reg_id_t r);
        return int'(w) * `OPCOL_REGS_PER_WARP + int'(r);
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    function automatic wb_t make_wb(input int idx, input mask_t mask);
        wb_t w;
        w.warp    = warp_id_t'(idx / `OPCOL_REGS_PER_WARP);
        w.reg_num = reg_id_t'(idx % `OPCOL_REGS_PER_WARP);
        w.mask    = mask;
        for (int i = 0; i < `OPCOL_LANES; i++) begin
            w.data[i*`OPCOL_LANE_W +: `OPCOL_LANE_W] = $urandom;
        end
        return w;
    endfunction

    function automatic issue_t make_issue(input warp_id_t w, input reg_id_t s1, input logic v1,
                                          input reg_id_t s2, input logic v2);
        issue_t      is;
        logic [95:0] bits;
        bits          = {$urandom, $urandom, $urandom};
        is.warp       = w;
        is.src1       = s1;
        is.src1_valid = v1;
        is.src2       = s2;
        is.src2_valid = v2;
        is.ctrl       = bits[$bits(ctrl_t)-1:0];
        is.ctrl.instr = next_tag;   // unique tag per instruction
        next_tag++;
        return is;
    endfunction

    function automatic void model_write(input wb_t w);
        int idx;
        idx = reg_index(w.warp, w.reg_num);
        for (int i = 0; i < `OPCOL_LANES; i++) begin
            if (w.mask[i]) regs[idx][i*`OPCOL_LANE_W +: `OPCOL_LANE_W] =
                w.data[i*`OPCOL_LANE_W +: `OPCOL_LANE_W];
        end
    endfunction

    function automatic void record_issue(input issue_t is);
        dispatch_t d;
        d.ctrl      = is.ctrl;
        d.src1_data = is.src1_valid ? regs[reg_index(is.warp, is.src1)] : '0;
        d.src2_data = is.src2_valid ? regs[reg_index(is.warp, is.src2)] : '0;
        exp_disp[is.ctrl.instr] = d;
        issued[is.ctrl.instr]   = is;
        if (is.src1_valid) inflight[reg_index(is.warp, is.src1)]++;
        if (is.src2_valid) inflight[reg_index(is.warp, is.src2)]++;
    endfunction

    task automatic check_dispatch(input dispatch_t d, input logic on_mem);
        string       port;
        int unsigned tag;
        issue_t      is;
        port = on_mem ? "mem" : "alu";
        tag  = d.ctrl.instr;
        if (!exp_disp.exists(tag)) begin
            errors++;
            $display("ERROR at %0t: %s port dispatched tag %h that is not outstanding",
                     $time, port, tag);
            return;
        end
        is = issued[tag];
        check_value({port, " is_mem"}, 256'(on_mem),
                    256'(is.ctrl.mem_read | is.ctrl.mem_write));
        check_value({port, ".ctrl"}, 256'(d.ctrl), 256'(exp_disp[tag].ctrl));
        check_value({port, ".src1_data"}, d.src1_data, exp_disp[tag].src1_data);
        check_value({port, ".src2_data"}, d.src2_data, exp_disp[tag].src2_data);
        if (is.src1_valid) inflight[reg_index(is.warp, is.src1)]--;
        if (is.src2_valid) inflight[reg_index(is.warp, is.src2)]--;
        exp_disp.delete(tag);
        issued.delete(tag);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (alu_valid) check_dispatch(alu, 1'b0);
            if (mem_valid) check_dispatch(mem, 1'b1);
        end
    end

    task automatic drive_cycle(input logic do_wb, input wb_t w, input logic do_iss,
                               input issue_t is);
        @(posedge clk);
        wb_valid    <= do_wb;
        wb          <= w;
        issue_valid <= do_iss;
        issue       <= is;
        if (do_wb) model_write(w);   // lands before any read of this issue
        if (do_iss) record_issue(is);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    // full sampled mid-cycle, one spare cycle so it covers the last allocation
    task automatic issue_when_free(input issue_t is, input logic do_wb, input wb_t w);
        @(negedge clk);
        while (full) begin
            idle_cycle();
            @(negedge clk);
        end
        drive_cycle(do_wb, w, 1'b1, is);
        idle_cycle();
    endtask

    task automatic drain();
        while (exp_disp.num() != 0) idle_cycle();
        repeat (4) idle_cycle();
    endtask

    task automatic finish_test(input string name, input int e0);
        drain();
        tests_run++;
        if (errors == e0) tests_passed++;
        $display("%-16s %s, %0d errors", name, (errors == e0) ? "passed" : "FAILED", errors - e0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst         <= 1'b1;
        wb_valid    <= 1'b0;
        issue_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_init_write();
        int e0;
        e0 = errors;
        for (int i = 0; i < NREGS; i++) drive_cycle(1'b1, make_wb(i, '1), 1'b0, '0);
        for (int i = 0; i < NREGS; i++) begin
            issue_when_free(make_issue(warp_id_t'(i / 8), reg_id_t'(i % 8), 1'b1, '0, 1'b0),
                            1'b0, '0);
        end
        finish_test("init_write", e0);
    endtask

    task automatic run_masked_write();
        int e0;
        e0 = errors;
        for (int n = 0; n < 32; n++) begin
            drive_cycle(1'b1, make_wb(int'($urandom % NREGS), mask_t'($urandom)), 1'b0, '0);
        end
        for (int i = 0; i < NREGS; i += 2) begin   // pairs of neighbours in one warp
            issue_when_free(make_issue(warp_id_t'(i / 8), reg_id_t'(i % 8), 1'b1,
                                       reg_id_t'(i % 8 + 1), 1'b1), 1'b0, '0);
        end
        finish_test("masked_write", e0);
    endtask

    task automatic run_class_routing();
        int e0;
        e0 = errors;
        for (int n = 0; n < 64; n++) begin
            issue_when_free(make_issue(warp_id_t'($urandom), reg_id_t'($urandom), 1'($urandom),
                                       reg_id_t'($urandom), 1'($urandom)), 1'b0, '0);
        end
        finish_test("class_routing", e0);
    endtask

    task automatic run_bank_conflict();
        int       e0;
        int       base;
        int       wbase;
        int       widx;
        warp_id_t w;
        warp_id_t w2;
        logic     do_wb;
        e0 = errors;
        for (int n = 0; n < 48; n++) begin
            w     = warp_id_t'($urandom);
            w2    = warp_id_t'($urandom);
            base  = (8 + CONFLICT_BANK - int'(w)) % 4;   // row pair of this warp in the bank
            wbase = (8 + CONFLICT_BANK - int'(w2)) % 4;
            widx  = reg_index(w2, reg_id_t'(wbase + 4 * int'($urandom % 2)));
            do_wb = 1'($urandom) && (inflight[widx] == 0);
            issue_when_free(make_issue(w, reg_id_t'(base + 4 * int'($urandom % 2)), 1'b1,
                                       reg_id_t'(base + 4 * int'($urandom % 2)), 1'b1),
                            do_wb, make_wb(widx, mask_t'($urandom)));
        end
        finish_test("bank_conflict", e0);
    endtask

    // warp 1 regs 3 and 7 sit in bank 0, held off by writes to warp 0 reg 0
    task automatic fill_collectors();
        for (int n = 0; n < `OPCOL_ENTRIES; n++) begin
            drive_cycle(1'b1, make_wb(0, '1), 1'b1,
                        make_issue(warp_id_t'(1), reg_id_t'(3), 1'b1, reg_id_t'(7), 1'b1));
            drive_cycle(1'b1, make_wb(0, '1), 1'b0, '0);
            @(negedge clk);
            check_value("full", 256'(full), 256'(n == `OPCOL_ENTRIES - 1));
        end
    endtask

    task automatic run_full_flag();
        int e0;
        int waited;
        e0 = errors;
        @(negedge clk);
        check_value("full", 256'(full), '0);
        fill_collectors();
        waited = 0;
        do begin
            idle_cycle();
            @(negedge clk);
            waited++;
        end while (full && waited < 20);
        if (full) begin
            errors++;
            $display("ERROR at %0t: full still high %0d cycles after writes stopped",
                     $time, waited);
        end
        drain();
        fill_collectors();
        apply_reset();
        exp_disp.delete();
        issued.delete();
        foreach (inflight[i]) inflight[i] = 0;
        @(negedge clk);
        check_value("full after reset", 256'(full), '0);
        check_value("alu_valid after reset", 256'(alu_valid), '0);
        check_value("mem_valid after reset", 256'(mem_valid), '0);
        repeat (12) idle_cycle();   // stray dispatch shows up as unknown tag
        finish_test("full_flag", e0);
    endtask

    initial begin
        void'($urandom(32'he050));
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        wb_valid    = 1'b0;
        wb          = '0;
        foreach (inflight[i]) inflight[i] = 0;
        apply_reset();
        run_init_write();
        run_masked_write();
        run_class_routing();
        run_bank_conflict();
        run_full_flag();
        $display("%0d of %0d tests passed, %0d errors, %0d cycles",
                 tests_passed, tests_run, errors, cycles);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: opcol.f
+incdir+hdl
hdl/opcol_pkg.sv
hdl/collector_units.sv
hdl/reg_map.sv
hdl/bank_queue.sv
hdl/reg_bank.sv
hdl/dispatch_arbiter.sv
hdl/opcol_top.sv
bench/opcol_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the operand collector testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 --top-module opcol_tb -Mdir "$BUILD_DIR" -f opcol.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vopcol_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
